/* dv/tb_soc_usb.sv */
module tb_soc_usb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int EP_AW = 8;

	logic               clk_sys = 1'b0;
	logic               clk_48m = 1'b0;
	logic               rst;
	usb_pkg::bus_req_t  wb_req;
	logic [1:0]         wb_cyc;
	logic [31:0]        wb_rdata;
	logic [1:0]         wb_ack;

	int                 seed = 72;
	int                 mismatches = 0;
	int                 timeouts = 0;
	int                 sys_cycles = 0;
	logic [31:0]        rnd;

	// Transmit words as software wrote them
	logic [usb_pkg::ep_dw-1:0] shadow [0:2**EP_AW-1];

	soc_usb #(.EP_AW(EP_AW)) i_dut (
		.clk_sys    (clk_sys),
		.clk_48m    (clk_48m),
		.rst        (rst),
		.wb_req_i   (wb_req),
		.wb_cyc_i   (wb_cyc),
		.wb_rdata_o (wb_rdata),
		.wb_ack_o   (wb_ack)
	);

	always #20 clk_sys = ~clk_sys;
	always #10.4 clk_48m = ~clk_48m;

	always @(posedge clk_sys)
		sys_cycles <= sys_cycles + 1;

	// ------------------------------
	// Compare tasks
	// ------------------------------

	task automatic check_word(input string what, input logic [usb_pkg::ep_dw-1:0] exp,
		input logic [usb_pkg::ep_dw-1:0] act);
		if (act !== exp) begin
			$display("Mismatch at %0t: %s expected %h, got %h", $time, what, exp, act);
			mismatches++;
		end
	endtask

	task automatic check_csr(input string what, input usb_pkg::csr_data_t exp,
		input usb_pkg::csr_data_t act);
		if (act !== exp) begin
			$display("Mismatch at %0t: %s expected %h, got %h", $time, what, exp, act);
			mismatches++;
		end
	endtask

	task automatic check_ack(input string what, input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp) begin
			$display("Mismatch at %0t: %s expected ack %b, got %b", $time, what, exp, act);
			mismatches++;
		end
	endtask

	// ------------------------------
	// Bus tasks
	// ------------------------------

	task automatic bus_access(input int sel, input logic [11:0] addr, input logic [31:0] wdata,
		input logic we, output logic [31:0] rdata);
		int   waited;
		logic got;
		@(posedge clk_sys);
		#2;
		wb_req.addr  = addr;
		wb_req.wdata = wdata;
		wb_req.we    = we;
		wb_cyc[sel]  = 1'b1;
		waited = 0;
		got    = 1'b0;
		rdata  = '0;
		while (!got && waited < 100) begin
			@(posedge clk_sys);
			#1;
			waited++;
			if (wb_ack[sel]) begin
				got   = 1'b1;
				rdata = wb_rdata;
			end
		end
		#1;
		wb_cyc    = 2'b00;
		wb_req.we = 1'b0;
		if (!got) begin
			$display("Timeout: select %0d access to address %h was not acknowledged in 100 cycles",
				sel, addr);
			timeouts++;
		end
	endtask

	task automatic bus_write(input int sel, input logic [11:0] addr, input logic [31:0] wdata);
		logic [31:0] unused;
		bus_access(sel, addr, wdata, 1'b1, unused);
	endtask

	task automatic bus_read(input int sel, input logic [11:0] addr, output logic [31:0] rdata);
		bus_access(sel, addr, 32'h0, 1'b0, rdata);
	endtask

	// Poll status until the sticky done bit shows
	task automatic wait_done();
		logic [31:0] rd;
		int          t0;
		logic        seen;
		t0   = sys_cycles;
		seen = 1'b0;
		while (!seen && (sys_cycles - t0) < 2000) begin
			bus_read(0, usb_pkg::csr_addr_status, rd);
			seen = rd[1];
		end
		if (!seen) begin
			$display("Timeout: status never showed done within 2000 cycles");
			timeouts++;
		end
	endtask

	// ------------------------------
	// Reference model
	// ------------------------------

	// Bit-serial CRC16 with bytes LSB first so word bits go 0 to 31
	function automatic usb_pkg::csr_data_t crc16_model(input int n);
		usb_pkg::csr_data_t r;
		logic               fb;
		r = usb_pkg::crc16_init;
		for (int w = 0; w < n; w++) begin
			for (int k = 0; k < usb_pkg::ep_dw; k++) begin
				fb = r[0] ^ shadow[w][k];
				r  = r >> 1;
				if (fb)
					r = r ^ usb_pkg::crc16_poly_refl;
			end
		end
		return ~r;
	endfunction

	task automatic fill_tx(input int n);
		for (int w = 0; w < n; w++) begin
			rnd       = $random(seed);
			shadow[w] = rnd;
			bus_write(1, w[11:0], rnd);
		end
	endtask

	// Receive buffer and CRC against the model
	task automatic check_result(input int n);
		logic [31:0] rd;
		bus_read(0, usb_pkg::csr_addr_status, rd);
		check_csr("status after done", 16'h0002, rd[15:0]);
		bus_read(0, usb_pkg::csr_addr_crc, rd);
		check_csr($sformatf("crc for len %0d", n), crc16_model(n), rd[15:0]);
		for (int w = 0; w < n; w++) begin
			bus_read(1, w[11:0], rd);
			check_word($sformatf("rx word %0d", w), shadow[w], rd);
		end
	endtask

	task automatic run_loopback(input int n);
		fill_tx(n);
		bus_write(0, usb_pkg::csr_addr_len, n);
		bus_write(0, usb_pkg::csr_addr_ctrl, 32'h1);
		wait_done();
		check_result(n);
	endtask

	// Select 1 must ack on the first edge after cyc and for one cycle only
	task automatic ep_ack_probe(input logic [11:0] addr);
		@(posedge clk_sys);
		#2;
		wb_req.addr  = addr;
		wb_req.wdata = $random(seed);
		wb_req.we    = 1'b1;
		wb_cyc[1]    = 1'b1;
		@(posedge clk_sys);
		#1;
		check_ack("select 1 one cycle after cyc", 2'b10, wb_ack);
		#1;
		wb_cyc    = 2'b00;
		wb_req.we = 1'b0;
		@(posedge clk_sys);
		#1;
		check_ack("select 1 after cyc drop", 2'b00, wb_ack);
	endtask

	// ------------------------------
	// Sequence
	// ------------------------------

	initial begin
		logic [31:0] rd;
		int          len;
		rst    = 1'b1;
		wb_req = '0;
		wb_cyc = 2'b00;
		repeat (8) @(posedge clk_sys);
		#2;
		rst = 1'b0;

		// Quiet bus and then the reset values
		repeat (20) begin
			@(posedge clk_sys);
			#1;
			check_ack("idle bus", 2'b00, wb_ack);
		end
		bus_read(0, usb_pkg::csr_addr_status, rd);
		check_csr("status after reset", 16'h0000, rd[15:0]);
		bus_read(0, usb_pkg::csr_addr_len, rd);
		check_csr("len after reset", 16'h0000, rd[15:0]);
		bus_read(0, usb_pkg::csr_addr_crc, rd);
		check_csr("crc after reset", 16'h0000, rd[15:0]);

		// Len register through the crossing keeps 9 bits
		repeat (12) begin
			rnd = $random(seed);
			bus_write(0, usb_pkg::csr_addr_len, rnd);
			bus_read(0, usb_pkg::csr_addr_len, rd);
			check_csr("len readback", rnd[15:0] & 16'h01FF, rd[15:0]);
		end

		repeat (6) begin
			rnd = $random(seed);
			ep_ack_probe(rnd[11:0]);
		end

		repeat (4) begin
			rnd = $random(seed);
			run_loopback(rnd % 257);
		end
		run_loopback(256);
		run_loopback(0);

		// Second start while busy with len changed under the running engine
		rnd = $random(seed);
		len = 200 + rnd % 57;
		fill_tx(len);
		bus_write(0, usb_pkg::csr_addr_len, len);
		bus_write(0, usb_pkg::csr_addr_ctrl, 32'h1);
		bus_write(0, usb_pkg::csr_addr_len, 32'h1);
		bus_write(0, usb_pkg::csr_addr_ctrl, 32'h1);
		bus_read(0, usb_pkg::csr_addr_status, rd);
		check_csr("status while busy", 16'h0001, rd[15:0]);
		wait_done();
		check_result(len);

		// A fresh start on new words drops done until the new run ends
		fill_tx(len);
		bus_write(0, usb_pkg::csr_addr_len, len);
		bus_write(0, usb_pkg::csr_addr_ctrl, 32'h1);
		bus_read(0, usb_pkg::csr_addr_status, rd);
		check_csr("status after restart", 16'h0001, rd[15:0]);
		wait_done();
		check_result(len);

		$display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* rtl/soc_usb.sv */
module soc_usb #(
	parameter int EP_AW = 8
) (
	input  logic              clk_sys,
	input  logic              clk_48m,
	input  logic              rst,

	// System bus slave, two selects
	input  usb_pkg::bus_req_t wb_req_i,
	input  logic [1:0]        wb_cyc_i,
	output logic [31:0]       wb_rdata_o,
	output logic [1:0]        wb_ack_o
);

	// Register path in the 48 MHz domain
	usb_pkg::csr_req_t   csr_req;
	logic                csr_stb;
	usb_pkg::csr_data_t  csr_rdata;
	logic                csr_ack;
	usb_pkg::csr_data_t  csr_rdata_sys;

	// Engine control
	logic                eng_start;
	logic [EP_AW:0]      eng_len;
	logic                eng_busy;
	logic                eng_done;
	usb_pkg::csr_data_t  eng_crc;

	// Endpoint buffers
	logic                      tx_re;
	logic [EP_AW-1:0]          tx_raddr;
	logic [usb_pkg::ep_dw-1:0] tx_rdata;
	logic                      tx_we;
	logic                      rx_we;
	logic [EP_AW-1:0]          rx_waddr;
	logic [usb_pkg::ep_dw-1:0] rx_wdata;
	logic [usb_pkg::ep_dw-1:0] ep_rdata;
	logic                      ack_ep;

	// ------------------------------
	// Select 0, registers
	// ------------------------------

	xclk_wb xclk_i (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.s_req_i   (wb_req_i),
		.s_cyc_i   (wb_cyc_i[0]),
		.s_rdata_o (csr_rdata_sys),
		.s_ack_o   (wb_ack_o[0]),
		.clk_48m   (clk_48m),
		.m_req_o   (csr_req),
		.m_stb_o   (csr_stb),
		.m_rdata_i (csr_rdata),
		.m_ack_i   (csr_ack)
	);

	usb_csr #(.EP_AW(EP_AW)) csr_i (
		.clk_48m (clk_48m),
		.rst     (rst),
		.req_i   (csr_req),
		.stb_i   (csr_stb),
		.rdata_o (csr_rdata),
		.ack_o   (csr_ack),
		.start_o (eng_start),
		.len_o   (eng_len),
		.busy_i  (eng_busy),
		.done_i  (eng_done),
		.crc_i   (eng_crc)
	);

	usb_pkt_engine #(.EP_AW(EP_AW)) engine_i (
		.clk_48m    (clk_48m),
		.rst        (rst),
		.start_i    (eng_start),
		.len_i      (eng_len),
		.busy_o     (eng_busy),
		.done_o     (eng_done),
		.crc_o      (eng_crc),
		.tx_re_o    (tx_re),
		.tx_raddr_o (tx_raddr),
		.tx_rdata_i (tx_rdata),
		.rx_we_o    (rx_we),
		.rx_waddr_o (rx_waddr),
		.rx_wdata_o (rx_wdata)
	);

	// ------------------------------
	// Select 1, endpoint buffers
	// ------------------------------

	// Write only in the first cycle of the access
	assign tx_we = wb_cyc_i[1] & wb_req_i.we & ~ack_ep;

	always_ff @(posedge clk_sys or posedge rst) begin
		if (rst)
			ack_ep <= 1'b0;
		else
			ack_ep <= wb_cyc_i[1] & ~ack_ep;
	end

	assign wb_ack_o[1] = ack_ep;

	usb_ep_ram #(.EP_AW(EP_AW)) tx_buf_i (
		.wclk_i  (clk_sys),
		.we_i    (tx_we),
		.waddr_i (wb_req_i.addr[EP_AW-1:0]),
		.wdata_i (wb_req_i.wdata),
		.rclk_i  (clk_48m),
		.re_i    (tx_re),
		.raddr_i (tx_raddr),
		.rdata_o (tx_rdata)
	);

	// Read continuously, data is ready in the ack cycle
	usb_ep_ram #(.EP_AW(EP_AW)) rx_buf_i (
		.wclk_i  (clk_48m),
		.we_i    (rx_we),
		.waddr_i (rx_waddr),
		.wdata_i (rx_wdata),
		.rclk_i  (clk_sys),
		.re_i    (1'b1),
		.raddr_i (wb_req_i.addr[EP_AW-1:0]),
		.rdata_o (ep_rdata)
	);

	// Read data OR, each path is zero outside its ack
	assign wb_rdata_o = {16'h0000, csr_rdata_sys} | (ack_ep ? ep_rdata : 32'h0000_0000);

	assert property (@(posedge clk_sys) disable iff (rst) !(wb_cyc_i[0] && wb_cyc_i[1]));

endmodule

/* rtl/usb_csr.sv */
module usb_csr #(
	parameter int EP_AW = 8
) (
	input  logic                clk_48m,
	input  logic                rst,

	// Register access from the bridge
	input  usb_pkg::csr_req_t   req_i,
	input  logic                stb_i,
	output usb_pkg::csr_data_t  rdata_o,
	output logic                ack_o,

	// Packet engine control
	output logic                start_o,
	output logic [EP_AW:0]      len_o,
	input  logic                busy_i,
	input  logic                done_i,
	input  usb_pkg::csr_data_t  crc_i
);

	logic                wr_ctrl;
	logic                wr_len;
	logic                start_ok;
	logic                done_q;
	usb_pkg::csr_data_t  crc_q;

	// ------------------------------
	// Write decode
	// ------------------------------

	assign wr_ctrl = stb_i && req_i.we && (req_i.addr == usb_pkg::csr_addr_ctrl);
	assign wr_len  = stb_i && req_i.we && (req_i.addr == usb_pkg::csr_addr_len);

	// Start only while idle, a pending pulse counts as busy
	assign start_ok = wr_ctrl && req_i.wdata[0] && !busy_i && !start_o;

	always_ff @(posedge clk_48m or posedge rst) begin
		if (rst) begin
			start_o <= 1'b0;
			len_o   <= '0;
			done_q  <= 1'b0;
			crc_q   <= '0;
		end else begin
			start_o <= start_ok;

			if (wr_len)
				len_o <= req_i.wdata[EP_AW:0];

			// Sticky done, cleared by the next accepted start
			if (start_ok)
				done_q <= 1'b0;
			else if (done_i)
				done_q <= 1'b1;

			if (done_i)
				crc_q <= crc_i;
		end
	end

	// ------------------------------
	// Read mux and ack
	// ------------------------------

	always_comb begin
		case (req_i.addr)
			usb_pkg::csr_addr_len:    rdata_o = {{(15 - EP_AW){1'b0}}, len_o};
			usb_pkg::csr_addr_status: rdata_o = {14'h0000, done_q, busy_i};
			usb_pkg::csr_addr_crc:    rdata_o = crc_q;
			// ctrl is write only, the rest is unmapped
			default:                  rdata_o = '0;
		endcase
	end

	// Single cycle answer
	assign ack_o = stb_i;

	// Length handed to the engine must fit the buffer
	assert property (@(posedge clk_48m) disable iff (rst)
		start_o |-> (len_o <= 2 ** EP_AW));

endmodule

/* rtl/usb_ep_ram.sv */
module usb_ep_ram #(
	parameter int EP_AW = 8
) (
	// Write port
	input  logic                      wclk_i,
	input  logic                      we_i,
	input  logic [EP_AW-1:0]          waddr_i,
	input  logic [usb_pkg::ep_dw-1:0] wdata_i,

	// Read port
	input  logic                      rclk_i,
	input  logic                      re_i,
	input  logic [EP_AW-1:0]          raddr_i,
	output logic [usb_pkg::ep_dw-1:0] rdata_o
);

	// ------------------------------
	// Storage
	// ------------------------------

	// One endpoint buffer, 2^EP_AW words
	logic [usb_pkg::ep_dw-1:0] mem [0:2**EP_AW-1];

	// Write side
	always_ff @(posedge wclk_i) begin
		if (we_i)
			mem[waddr_i] <= wdata_i;
	end

	// ------------------------------
	// Registered read
	// ------------------------------

	// Data appears the cycle after the address,
	// in the read clock domain
	always_ff @(posedge rclk_i) begin
		if (re_i)
			rdata_o <= mem[raddr_i];
	end

endmodule

/* rtl/usb_pkg.sv */
package usb_pkg;

	// ------------------------------
	// Bus and data widths
	// ------------------------------

	// Endpoint buffer word
	localparam int ep_dw = 32;

	// System bus request, held stable by the master until ack
	typedef struct packed {
		logic [11:0] addr;
		logic [31:0] wdata;
		logic        we;
	} bus_req_t;

	// Register request in the USB domain, data narrowed to 16 bits
	typedef struct packed {
		logic [11:0] addr;
		logic [15:0] wdata;
		logic        we;
	} csr_req_t;

	typedef logic [15:0] csr_data_t;

	// ------------------------------
	// Register map
	// ------------------------------

	// Bit 0 written as 1 starts the loopback run
	localparam logic [11:0] csr_addr_ctrl   = 12'h000;
	// Word count, 0 to 256
	localparam logic [11:0] csr_addr_len    = 12'h001;
	// Bit 0 busy, bit 1 done (sticky)
	localparam logic [11:0] csr_addr_status = 12'h002;
	localparam logic [11:0] csr_addr_crc    = 12'h003;

	// ------------------------------
	// USB data CRC16
	// ------------------------------

	// Reflected form, LSB first, result inverted at the end
	localparam csr_data_t crc16_init      = 16'hFFFF;
	localparam csr_data_t crc16_poly_refl = 16'hA001;

endpackage

/* rtl/usb_pkt_engine.sv */
module usb_pkt_engine #(
	parameter int EP_AW = 8
) (
	input  logic                      clk_48m,
	input  logic                      rst,

	// Control from the register file
	input  logic                      start_i,
	input  logic [EP_AW:0]            len_i,
	output logic                      busy_o,
	output logic                      done_o,
	output usb_pkg::csr_data_t        crc_o,

	// Transmit buffer read port
	output logic                      tx_re_o,
	output logic [EP_AW-1:0]          tx_raddr_o,
	input  logic [usb_pkg::ep_dw-1:0] tx_rdata_i,

	// Receive buffer write port
	output logic                      rx_we_o,
	output logic [EP_AW-1:0]          rx_waddr_o,
	output logic [usb_pkg::ep_dw-1:0] rx_wdata_o
);

	// Fold one word into the CRC, least significant byte first
	function automatic usb_pkg::csr_data_t crc16_word(
		input usb_pkg::csr_data_t        crc_in,
		input logic [usb_pkg::ep_dw-1:0] word
	);
		usb_pkg::csr_data_t c;
		c = crc_in;
		for (int b = 0; b < usb_pkg::ep_dw / 8; b++) begin
			c = c ^ {8'h00, word[8*b +: 8]};
			for (int i = 0; i < 8; i++) begin
				if (c[0])
					c = (c >> 1) ^ usb_pkg::crc16_poly_refl;
				else
					c = c >> 1;
			end
		end
		return c;
	endfunction

	logic                busy_q;
	logic                done_q;
	logic [EP_AW:0]      len_q;
	logic [EP_AW:0]      cnt;
	logic                rd_vld;
	logic [EP_AW-1:0]    rd_addr_q;
	usb_pkg::csr_data_t  crc_q;

	// ------------------------------
	// Read address counter
	// ------------------------------

	assign tx_re_o    = busy_q && (cnt != len_q);
	assign tx_raddr_o = cnt[EP_AW-1:0];

	always_ff @(posedge clk_48m or posedge rst) begin
		if (rst) begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
			len_q  <= '0;
			cnt    <= '0;
		end else begin
			done_q <= 1'b0;
			if (start_i) begin
				busy_q <= 1'b1;
				len_q  <= len_i;
				cnt    <= '0;
			end else if (busy_q) begin
				if (cnt != len_q) begin
					cnt <= cnt + 1'b1;
				end else begin
					// Last word lands on this edge
					busy_q <= 1'b0;
					done_q <= 1'b1;
				end
			end
		end
	end

	// ------------------------------
	// Write stage and CRC
	// ------------------------------

	always_ff @(posedge clk_48m or posedge rst) begin
		if (rst) begin
			rd_vld <= 1'b0;
			crc_q  <= usb_pkg::crc16_init;
		end else begin
			rd_vld <= tx_re_o;
			if (start_i)
				crc_q <= usb_pkg::crc16_init;
			else if (rd_vld)
				crc_q <= crc16_word(crc_q, tx_rdata_i);
		end
	end

	// Address of the word now on the RAM output
	always_ff @(posedge clk_48m) begin
		rd_addr_q <= tx_raddr_o;
	end

	assign rx_we_o    = rd_vld;
	assign rx_waddr_o = rd_addr_q;
	assign rx_wdata_o = tx_rdata_i;

	assign busy_o = busy_q;
	assign done_o = done_q;
	assign crc_o  = ~crc_q;

	assert property (@(posedge clk_48m) disable iff (rst) start_i |-> !busy_o);

endmodule

/* rtl/xclk_wb.sv */
module xclk_wb (
	// System side
	input  logic                clk_sys,
	input  logic                rst,
	input  usb_pkg::bus_req_t   s_req_i,
	input  logic                s_cyc_i,
	output usb_pkg::csr_data_t  s_rdata_o,
	output logic                s_ack_o,

	// USB side
	input  logic                clk_48m,
	output usb_pkg::csr_req_t   m_req_o,
	output logic                m_stb_o,
	input  usb_pkg::csr_data_t  m_rdata_i,
	input  logic                m_ack_i
);

	// ------------------------------
	// System domain request launch
	// ------------------------------

	usb_pkg::bus_req_t   s_req_q;
	logic                req_tgl;
	logic                pend;
	logic [2:0]          resp_sync;
	logic                resp_edge;
	// Reply toggle and held read data from the USB side
	logic                resp_tgl;
	usb_pkg::csr_data_t  m_rdata_q;

	// Response toggle back from the USB side through 2 flops and an edge detect
	assign resp_edge = resp_sync[2] ^ resp_sync[1];

	always_ff @(posedge clk_sys or posedge rst) begin
		if (rst) begin
			req_tgl   <= 1'b0;
			pend      <= 1'b0;
			resp_sync <= 3'b000;
			s_ack_o   <= 1'b0;
			s_rdata_o <= '0;
		end else begin
			resp_sync <= {resp_sync[1:0], resp_tgl};
			s_ack_o   <= resp_edge;
			// Zero when not acknowledging so the top can OR it
			s_rdata_o <= resp_edge ? m_rdata_q : '0;

			// New access once cyc is seen and the previous ack is over
			if (s_cyc_i && !pend && !s_ack_o) begin
				req_tgl <= ~req_tgl;
				pend    <= 1'b1;
			end else if (resp_edge) begin
				pend <= 1'b0;
			end
		end
	end

	// Request held here until the ack so clk_48m can sample it safely
	always_ff @(posedge clk_sys) begin
		if (s_cyc_i && !pend && !s_ack_o)
			s_req_q <= s_req_i;
	end

	// ------------------------------
	// USB domain strobe and reply
	// ------------------------------

	logic [2:0]          req_sync;
	logic                req_edge;

	assign req_edge = req_sync[2] ^ req_sync[1];

	always_ff @(posedge clk_48m or posedge rst) begin
		if (rst) begin
			req_sync <= 3'b000;
			m_stb_o  <= 1'b0;
			resp_tgl <= 1'b0;
		end else begin
			req_sync <= {req_sync[1:0], req_tgl};
			m_stb_o  <= req_edge;
			if (m_ack_i)
				resp_tgl <= ~resp_tgl;
		end
	end

	always_ff @(posedge clk_48m) begin
		if (req_edge) begin
			m_req_o.addr  <= s_req_q.addr;
			m_req_o.wdata <= s_req_q.wdata[15:0];
			m_req_o.we    <= s_req_q.we;
		end
		if (m_ack_i)
			m_rdata_q <= m_rdata_i;
	end

	// Register file may only answer a strobe of ours
	assert property (@(posedge clk_48m) disable iff (rst) m_ack_i |-> m_stb_o);

endmodule

/* soc_usb.f */
rtl/usb_pkg.sv
rtl/xclk_wb.sv
rtl/usb_ep_ram.sv
rtl/usb_csr.sv
rtl/usb_pkt_engine.sv
rtl/soc_usb.sv
dv/tb_soc_usb.sv
